//--- Makefile
# Verilator build and run of the pixel back end testbench

VERILATOR ?= verilator
TOP       ?= tbGpuPixel
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- hw/fbWriter.sv
`timescale 1ns/1ps

module fbWriter
#(
  parameter int FB_CREDITS = 2,
  parameter int FB_ADDR_W  = 13
)
(
  input  logic                         iClock,
  input  logic                         rstN,
  input  logic                         enable,
  input  logic                         mixValid,
  input  logic [gpuPkg::FB_WORD_W-1:0] mixWord,
  input  logic                         fbCredit, // sink freed one slot
  output logic                         mixReady,
  output logic                         fbWe,
  output logic [gpuPkg::FB_WORD_W-1:0] fbData,
  output logic [FB_ADDR_W-1:0]         fbAddr
);

  localparam int CRD_W = $clog2(FB_CREDITS + 1);

  logic [CRD_W-1:0] credits; // sink slots we may still fill
  logic             holdValid;

  ////////////////////////////////////////
  // output word and write strobe
  ////////////////////////////////////////

  // write only with a credit and the unit on, else keep the word
  assign fbWe     = holdValid && enable && (credits != '0);
  assign mixReady = !holdValid || fbWe;

  always_ff @(posedge iClock)
  begin
    if (mixValid && mixReady)
      fbData <= mixWord; // payload, no reset
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      holdValid <= 1'b0;
      credits   <= CRD_W'(FB_CREDITS); // sink starts empty
      fbAddr    <= '0;
    end
    else
    begin
      if (mixReady)
        holdValid <= mixValid;
      case ({fbCredit, fbWe})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits; // return and spend cancel
      endcase
      if (!enable)
        fbAddr <= '0;            // restart of frame
      else if (fbWe)
        fbAddr <= fbAddr + 1'b1; // wraps at 2**FB_ADDR_W
    end
  end

  // sink handed back more slots than it owns
  creditBound : assert property (@(posedge iClock) disable iff (!rstN)
    credits <= CRD_W'(FB_CREDITS));

endmodule

//--- hw/gpuPixelTop.sv
`timescale 1ns/1ps

module gpuPixelTop
#(
  parameter int ROW_FIFO_DEPTH = 4,  // = fetcher start credit
  parameter int FB_CREDITS     = 2,  // = sink start credit
  parameter int FB_ADDR_W      = 13
)
(
  input  logic                         iClock,
  input  logic                         rstN,
  input  logic                         regWe,
  input  gpuPkg::regSelT               regSel,
  input  logic [7:0]                   regData,
  input  logic                         rowValid,
  input  logic [7:0]                   bgHi,
  input  logic [7:0]                   bgLo,
  input  logic [7:0]                   sprHi,
  input  logic [7:0]                   sprLo,
  input  logic [7:0]                   sprAttr,
  input  logic                         fbCredit,
  output logic [7:0]                   lcdc,
  output gpuPkg::paletteT              bgp,
  output gpuPkg::paletteT              obp0,
  output gpuPkg::paletteT              obp1,
  output logic                         rowCredit,
  output logic                         fbWe,
  output logic [gpuPkg::FB_WORD_W-1:0] fbData,
  output logic [FB_ADDR_W-1:0]         fbAddr
);

  logic                         enable;
  logic                         rowOutValid;
  logic                         rowOutReady;
  logic [7:0]                   qBgHi;
  logic [7:0]                   qBgLo;
  logic [7:0]                   qSprHi;
  logic [7:0]                   qSprLo;
  logic [7:0]                   qSprAttr;
  logic                         mixValid;
  logic                         mixReady;
  logic [gpuPkg::FB_WORD_W-1:0] mixWord;

  ////////////////////////////////////////
  // cpu regs
  ////////////////////////////////////////

  gpuRegFile uRegFile
  (
    .iClock  (iClock),
    .rstN    (rstN),
    .regWe   (regWe),
    .regSel  (regSel),
    .regData (regData),
    .lcdc    (lcdc),
    .bgp     (bgp),
    .obp0    (obp0),
    .obp1    (obp1),
    .enable  (enable)
  );

  ////////////////////////////////////////
  // row path, fetcher to framebuffer
  ////////////////////////////////////////

  rowIngress #(.ROW_FIFO_DEPTH(ROW_FIFO_DEPTH)) uIngress
  (
    .iClock      (iClock),
    .rstN        (rstN),
    .enable      (enable),
    .rowValid    (rowValid),
    .bgHi        (bgHi),
    .bgLo        (bgLo),
    .sprHi       (sprHi),
    .sprLo       (sprLo),
    .sprAttr     (sprAttr),
    .rowOutReady (rowOutReady),
    .rowCredit   (rowCredit),
    .rowOutValid (rowOutValid),
    .outBgHi     (qBgHi),
    .outBgLo     (qBgLo),
    .outSprHi    (qSprHi),
    .outSprLo    (qSprLo),
    .outSprAttr  (qSprAttr)
  );

  pixelMixer uMixer
  (
    .iClock      (iClock),
    .rstN        (rstN),
    .rowInValid  (rowOutValid),
    .bgHi        (qBgHi),
    .bgLo        (qBgLo),
    .sprHi       (qSprHi),
    .sprLo       (qSprLo),
    .sprAttr     (qSprAttr),
    .bgp         (bgp),
    .obp0        (obp0),
    .obp1        (obp1),
    .mixReady    (mixReady),
    .rowOutReady (rowOutReady),
    .mixValid    (mixValid),
    .mixWord     (mixWord)
  );

  fbWriter #(.FB_CREDITS(FB_CREDITS), .FB_ADDR_W(FB_ADDR_W)) uWriter
  (
    .iClock   (iClock),
    .rstN     (rstN),
    .enable   (enable),
    .mixValid (mixValid),
    .mixWord  (mixWord),
    .fbCredit (fbCredit),
    .mixReady (mixReady),
    .fbWe     (fbWe),
    .fbData   (fbData),
    .fbAddr   (fbAddr)
  );

endmodule

//--- hw/gpuPkg.sv
package gpuPkg;

  ////////////////////////////////////////
  // cpu register map
  ////////////////////////////////////////

  typedef enum logic [1:0]
  {
    REG_LCDC = 2'd0, // lcd control
    REG_BGP  = 2'd1, // bg palette
    REG_OBP0 = 2'd2, // sprite palette 0
    REG_OBP1 = 2'd3  // sprite palette 1
  } regSelT;

  localparam int LCDC_ENABLE_BIT = 7; // lcdc: unit on
  localparam int SPRITE_PAL_BIT  = 4; // sprite attr: 1 picks obp1

  ////////////////////////////////////////
  // pixel types
  ////////////////////////////////////////

  // shade on screen, or raw colour code out of the tile planes
  typedef logic [1:0] shadeT;

  localparam shadeT COLOR_TRANSPARENT = 2'd0; // sprite code 0 lets bg through

  // one palette byte, seen by the cpu as a plain byte
  // and by the mixer as four shade slots, slot n for colour code n
  typedef union packed
  {
    logic [7:0]  raw;
    shadeT [3:0] shade;
  } paletteT;

  localparam int PIXELS_PER_ROW = 8;
  localparam int FB_WORD_W      = 2 * PIXELS_PER_ROW; // 16 bit fb word

endpackage

//--- hw/gpuRegFile.sv
`timescale 1ns/1ps

module gpuRegFile
(
  input  logic            iClock,
  input  logic            rstN,
  input  logic            regWe,   // cpu write strobe
  input  gpuPkg::regSelT  regSel,  // which reg
  input  logic [7:0]      regData, // cpu write data
  output logic [7:0]      lcdc,
  output gpuPkg::paletteT bgp,
  output gpuPkg::paletteT obp0,
  output gpuPkg::paletteT obp1,
  output logic            enable   // lcdc bit 7, shared by ingress and writer
);

  ////////////////////////////////////////
  // register bank
  ////////////////////////////////////////

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      lcdc     <= '0; // unit off after reset
      bgp.raw  <= '0;
      obp0.raw <= '0;
      obp1.raw <= '0;
    end
    else if (regWe)
    begin
      case (regSel)
        gpuPkg::REG_LCDC: lcdc     <= regData;
        gpuPkg::REG_BGP:  bgp.raw  <= regData;
        gpuPkg::REG_OBP0: obp0.raw <= regData;
        gpuPkg::REG_OBP1: obp1.raw <= regData;
        default:          lcdc     <= lcdc; // unreachable, enum covers all
      endcase
    end
  end

  assign enable = lcdc[gpuPkg::LCDC_ENABLE_BIT];

  // an x on the select would corrupt some palette silently
  regSelKnown : assert property (@(posedge iClock) disable iff (!rstN)
    regWe |-> !$isunknown(regSel));

endmodule

//--- hw/pixelMixer.sv
`timescale 1ns/1ps

module pixelMixer
(
  input  logic                         iClock,
  input  logic                         rstN,
  input  logic                         rowInValid,
  input  logic [7:0]                   bgHi,   // bg plane, high bit of code
  input  logic [7:0]                   bgLo,
  input  logic [7:0]                   sprHi,  // sprite plane
  input  logic [7:0]                   sprLo,
  input  logic [7:0]                   sprAttr,
  input  gpuPkg::paletteT              bgp,
  input  gpuPkg::paletteT              obp0,
  input  gpuPkg::paletteT              obp1,
  input  logic                         mixReady,
  output logic                         rowOutReady,
  output logic                         mixValid,
  output logic [gpuPkg::FB_WORD_W-1:0] mixWord
);

  localparam int NPIX = gpuPkg::PIXELS_PER_ROW;

  gpuPkg::paletteT              sprPal;  // obp0 or obp1 for this row
  gpuPkg::shadeT [NPIX-1:0]     bgLook;  // bg shades, comb
  gpuPkg::shadeT [NPIX-1:0]     sprLook; // sprite shades, comb
  gpuPkg::shadeT [NPIX-1:0]     sprCode; // raw sprite codes
  gpuPkg::shadeT [NPIX-1:0]     s1Bg;
  gpuPkg::shadeT [NPIX-1:0]     s1Spr;
  gpuPkg::shadeT [NPIX-1:0]     s1Code;
  logic [gpuPkg::FB_WORD_W-1:0] mixNext;
  logic                         s1Valid;
  logic                         s2Valid;
  logic                         s1Free;
  logic                         s2Free;

  // a stage takes a new item when empty or when its own item drains
  assign s2Free      = !s2Valid || mixReady;
  assign s1Free      = !s1Valid || s2Free;
  assign rowOutReady = s1Free;
  assign mixValid    = s2Valid;

  ////////////////////////////////////////
  // stage 1, palette lookup
  ////////////////////////////////////////

  always_comb
  begin
    sprPal = sprAttr[gpuPkg::SPRITE_PAL_BIT] ? obp1 : obp0;
    for (int i = 0; i < NPIX; i++)
    begin
      bgLook[i]  = bgp.shade[{bgHi[i], bgLo[i]}]; // slot picked by code
      sprCode[i] = {sprHi[i], sprLo[i]};
      sprLook[i] = sprPal.shade[sprCode[i]];      // same rule for both obp
    end
  end

  always_ff @(posedge iClock)
  begin
    if (rowInValid && s1Free)
    begin
      s1Bg   <= bgLook;
      s1Spr  <= sprLook;
      s1Code <= sprCode; // kept for the transparency test
    end
  end

  ////////////////////////////////////////
  // stage 2, sprite over bg and pack
  ////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < NPIX; i++)
      mixNext[2*i +: 2] = (s1Code[i] == gpuPkg::COLOR_TRANSPARENT) ? s1Bg[i] : s1Spr[i];
  end

  always_ff @(posedge iClock)
  begin
    if (s1Valid && s2Free)
      mixWord <= mixNext;
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
    end
    else
    begin
      if (s1Free)
        s1Valid <= rowInValid;
      if (s2Free)
        s2Valid <= s1Valid;
    end
  end

endmodule

//--- hw/rowIngress.sv
`timescale 1ns/1ps

module rowIngress
#(
  parameter int ROW_FIFO_DEPTH = 4
)
(
  input  logic       iClock,
  input  logic       rstN,
  input  logic       enable,
  input  logic       rowValid,    // fetcher push, needs a credit
  input  logic [7:0] bgHi,
  input  logic [7:0] bgLo,
  input  logic [7:0] sprHi,
  input  logic [7:0] sprLo,
  input  logic [7:0] sprAttr,
  input  logic       rowOutReady, // mixer can take a row
  output logic       rowCredit,   // one per row handed on
  output logic       rowOutValid,
  output logic [7:0] outBgHi,
  output logic [7:0] outBgLo,
  output logic [7:0] outSprHi,
  output logic [7:0] outSprLo,
  output logic [7:0] outSprAttr
);

  localparam int PTR_W = (ROW_FIFO_DEPTH > 1) ? $clog2(ROW_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(ROW_FIFO_DEPTH + 1);
  localparam int ROW_W = 5 * 8; // five bytes per row

  logic [ROW_W-1:0] rowMem [ROW_FIFO_DEPTH]; // row storage
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;                    // rows held
  logic             deq;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge iClock)
  begin
    if (rowValid)
      rowMem[wrPtr] <= {bgHi, bgLo, sprHi, sprLo, sprAttr};
  end

  assign {outBgHi, outBgLo, outSprHi, outSprLo, outSprAttr} = rowMem[rdPtr];

  // nothing leaves while the unit is off
  assign rowOutValid = (count != '0) && enable;
  assign deq         = rowOutValid && rowOutReady;

  ////////////////////////////////////////
  // pointers, fill count, credit
  ////////////////////////////////////////

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      rowCredit <= 1'b0;
    end
    else
    begin
      if (rowValid)
        wrPtr <= (wrPtr == PTR_W'(ROW_FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (deq)
        rdPtr <= (rdPtr == PTR_W'(ROW_FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      case ({rowValid, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
      rowCredit <= deq; // credit back one cycle after dequeue
    end
  end

  // fetcher overran its credits
  noWriteWhenFull : assert property (@(posedge iClock) disable iff (!rstN)
    rowValid |-> count < CNT_W'(ROW_FIFO_DEPTH));

  // a read past empty would leave an empty fifo with split pointers
  noReadWhenEmpty : assert property (@(posedge iClock) disable iff (!rstN)
    count == '0 |-> wrPtr == rdPtr);

endmodule

//--- list.f
hw/gpuPkg.sv
+incdir+verif
hw/gpuRegFile.sv
hw/rowIngress.sv
hw/pixelMixer.sv
hw/fbWriter.sv
hw/gpuPixelTop.sv
verif/tbGpuPixel.sv

//--- verif/tbTasks.svh
////////////////////////////////////////
// helpers
////////////////////////////////////////

task automatic reportError(input string msg);
  $display("error at %0t ns: %s", $time, msg);
  $display("*** TEST FAILED ***");
  $fatal(1, "check failed");
endtask

function automatic logic [7:0] rnd8();
  return 8'($random(seed));
endfunction

function automatic int fetcherCredits();
  return FIFO_DEPTH - (rowsSent - creditsBack);
endfunction

// palette field n holds the shade for colour code n, sprite code 0 shows bg
function automatic logic [15:0] refWord(input logic [7:0] bH, input logic [7:0] bL,
                                        input logic [7:0] sH, input logic [7:0] sL,
                                        input logic [7:0] attr);
  logic [15:0] word;
  logic [7:0]  pal;
  int          bCode;
  int          sCode;
  pal = attr[4] ? obp1Val : obp0Val; // attr bit 4 picks obp1
  for (int i = 0; i < 8; i++)
  begin
    bCode = {bH[i], bL[i]};
    sCode = {sH[i], sL[i]};
    word[2*i +: 2] = (sCode == 0) ? bgpVal[2*bCode +: 2] : pal[2*sCode +: 2];
  end
  return word;
endfunction

task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] want);
  assert (got === want) else reportError($sformatf("%s reads %h, expected %h", name, got, want));
endtask

task automatic writeReg(input gpuPkg::regSelT sel, input logic [7:0] data);
  @(negedge iClock);
  regWe   = 1'b1;
  regSel  = sel;
  regData = data;
  @(negedge iClock);
  regWe = 1'b0;
  case (sel)
    gpuPkg::REG_LCDC: tbEnable = data[7];
    gpuPkg::REG_BGP:  bgpVal   = data;
    gpuPkg::REG_OBP0: obp0Val  = data;
    default:          obp1Val  = data;
  endcase
endtask

// changed on the rising edge, the sink reads it on the falling one
task automatic configureSink(input int delay, input bit hold);
  @(posedge iClock);
  sinkDelay = delay;
  sinkHold  = hold;
endtask

// fetcher side, one row per credit
task automatic sendRow(input logic [7:0] bH, input logic [7:0] bL, input logic [7:0] sH,
                       input logic [7:0] sL, input logic [7:0] attr);
  @(negedge iClock);
  while (fetcherCredits() <= 0)
    @(negedge iClock);
  rowValid = 1'b1;
  bgHi     = bH;
  bgLo     = bL;
  sprHi    = sH;
  sprLo    = sL;
  sprAttr  = attr;
  expQ.push_back(refWord(bH, bL, sH, sL, attr));
  rowsSent++;
  @(negedge iClock);
  rowValid = 1'b0;
endtask

// all words out and every sink slot back
task automatic waitIdle();
  while (expQ.size() != 0 || retQ.size() != 0)
    @(negedge iClock);
  assert (fetcherCredits() == FIFO_DEPTH)
    else reportError($sformatf("fetcher holds %0d credits when idle, expected %0d",
                               fetcherCredits(), FIFO_DEPTH));
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic testRegisters();
  writeReg(gpuPkg::REG_BGP, 8'h4e); // no identity map, so the lookup shows
  checkByte("bgp", bgp.raw, 8'h4e);
  writeReg(gpuPkg::REG_OBP0, 8'hd2);
  checkByte("obp0", obp0.raw, 8'hd2);
  writeReg(gpuPkg::REG_OBP1, 8'h1b);
  checkByte("obp1", obp1.raw, 8'h1b);
  writeReg(gpuPkg::REG_LCDC, 8'h91); // unit on
  checkByte("lcdc", lcdc, 8'h91);
endtask

// sprite planes zero, addresses from 0 checked by the monitor
task automatic testBackgroundOnly();
  configureSink(0, 1'b0);
  repeat (8)
    sendRow(rnd8(), rnd8(), 8'h00, 8'h00, rnd8());
  waitIdle();
endtask

task automatic testSpritePriority();
  configureSink(3, 1'b0);
  repeat (16)
    sendRow(rnd8(), rnd8(), rnd8(), rnd8(), rnd8());
  waitIdle();
endtask

// 9 rows fill sink slots, writer, both mixer stages and the fifo
task automatic testBackPressure();
  int startWrites;
  configureSink(0, 1'b1);
  startWrites = writeCount;
  repeat (FB_CRED + 3 + FIFO_DEPTH)
    sendRow(rnd8(), rnd8(), rnd8(), rnd8(), rnd8());
  repeat (30) @(negedge iClock); // quiet window, nothing may move
  assert (writeCount - startWrites == FB_CRED)
    else reportError($sformatf("%0d writes without credit, expected %0d",
                               writeCount - startWrites, FB_CRED));
  assert (fetcherCredits() == 0)
    else reportError($sformatf("fetcher got %0d credits back from a full fifo",
                               fetcherCredits()));
  configureSink(0, 1'b0);
  waitIdle();
endtask

task automatic testCreditAccounting();
  configureSink(5, 1'b0);
  repeat (12)
    sendRow(rnd8(), rnd8(), rnd8(), rnd8(), rnd8());
  waitIdle();
  assert (creditsBack == rowsSent)
    else reportError($sformatf("%0d row credits for %0d rows", creditsBack, rowsSent));
endtask

// rows wait in the fifo while off, first write after enable goes to 0
task automatic testDisable();
  int startWrites;
  configureSink(0, 1'b0);
  writeReg(gpuPkg::REG_LCDC, 8'h11);
  startWrites = writeCount;
  repeat (3)
    sendRow(rnd8(), rnd8(), rnd8(), rnd8(), rnd8());
  repeat (10) @(negedge iClock);
  assert (writeCount == startWrites) else reportError("rows were written while disabled");
  assert (fbAddr == '0) else reportError($sformatf("fbAddr %0d while disabled", fbAddr));
  assert (fetcherCredits() == FIFO_DEPTH - 3)
    else reportError("rows left the fifo while disabled");
  writeReg(gpuPkg::REG_LCDC, 8'h91);
  waitIdle();
  assert (writeCount == startWrites + 3)
    else reportError($sformatf("%0d writes after enable, expected 3", writeCount - startWrites));
endtask

//--- verif/tbGpuPixel.sv
`timescale 1ns/1ps

module tbGpuPixel;

  localparam int FIFO_DEPTH      = 4;
  localparam int FB_CRED         = 2;
  localparam int ADDR_W          = 13;
  localparam int TOTAL_ROWS      = 48;                      // rows over all tests
  localparam int WATCHDOG_CYCLES = TOTAL_ROWS * 20 + 600;   // 20 per row plus margin

  logic                  iClock;
  logic                  rstN;
  logic                  regWe;
  gpuPkg::regSelT        regSel;
  logic [7:0]            regData;
  logic                  rowValid;
  logic [7:0]            bgHi;
  logic [7:0]            bgLo;
  logic [7:0]            sprHi;
  logic [7:0]            sprLo;
  logic [7:0]            sprAttr;
  logic                  fbCredit;
  logic [7:0]            lcdc;
  gpuPkg::paletteT       bgp;
  gpuPkg::paletteT       obp0;
  gpuPkg::paletteT       obp1;
  logic                  rowCredit;
  logic                  fbWe;
  logic [15:0]           fbData;
  logic [ADDR_W-1:0]     fbAddr;

  ////////////////////////////////////////
  // model state
  ////////////////////////////////////////

  int                seed = 32'h48c24004;
  logic [15:0]       expQ[$];       // words still owed, in row order
  int                retQ[$];       // cycle of each write the sink has not freed
  int                cycle;
  int                rowsSent;
  int                creditsBack;   // rowCredit pulses seen
  int                writeCount;
  int                sinkDelay;     // cycles before a slot is freed
  bit                sinkHold;      // sink keeps every slot
  bit                tbEnable;      // model copy of lcdc bit 7
  logic [ADDR_W-1:0] expAddr;
  logic [7:0]        bgpVal;
  logic [7:0]        obp0Val;
  logic [7:0]        obp1Val;

  `include "tbTasks.svh"

  gpuPixelTop #(.ROW_FIFO_DEPTH(FIFO_DEPTH), .FB_CREDITS(FB_CRED), .FB_ADDR_W(ADDR_W)) i_dut
  (
    .iClock    (iClock),
    .rstN      (rstN),
    .regWe     (regWe),
    .regSel    (regSel),
    .regData   (regData),
    .rowValid  (rowValid),
    .bgHi      (bgHi),
    .bgLo      (bgLo),
    .sprHi     (sprHi),
    .sprLo     (sprLo),
    .sprAttr   (sprAttr),
    .fbCredit  (fbCredit),
    .lcdc      (lcdc),
    .bgp       (bgp),
    .obp0      (obp0),
    .obp1      (obp1),
    .rowCredit (rowCredit),
    .fbWe      (fbWe),
    .fbData    (fbData),
    .fbAddr    (fbAddr)
  );

  initial
  begin
    iClock = 1'b0;
    forever #20 iClock = ~iClock; // 40 ns period
  end

  ////////////////////////////////////////
  // framebuffer sink and output checks
  ////////////////////////////////////////

  always @(posedge iClock)
  begin
    cycle++;
    if (rstN)
    begin
      if (rowCredit)
        creditsBack++;
      assert (creditsBack <= rowsSent)
        else reportError("more row credits returned than rows sent");
      if (fbWe)
      begin
        assert (tbEnable) else reportError("framebuffer write while the unit is disabled");
        assert (expQ.size() > 0) else reportError("framebuffer write with no row outstanding");
        assert (fbData === expQ[0])
          else reportError($sformatf("fbData %h, expected %h", fbData, expQ[0]));
        assert (fbAddr === expAddr)
          else reportError($sformatf("fbAddr %0d, expected %0d", fbAddr, expAddr));
        void'(expQ.pop_front());
        expAddr++;                // wraps like the 13 bit counter
        writeCount++;
        retQ.push_back(cycle);
      end
      if (!tbEnable)
        expAddr = '0;             // frame restarts at 0
    end
  end

  // slot freed sinkDelay cycles after its write, one per cycle
  always @(negedge iClock)
  begin
    fbCredit = 1'b0;
    if (!sinkHold && retQ.size() > 0 && cycle >= retQ[0] + sinkDelay)
    begin
      void'(retQ.pop_front());
      fbCredit = 1'b1;
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge iClock);
    $display("timeout: the run was still busy after %0d clock cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial
  begin
    rstN     = 1'b0;
    regWe    = 1'b0;
    regSel   = gpuPkg::REG_LCDC;
    regData  = '0;
    rowValid = 1'b0;
    bgHi     = '0;
    bgLo     = '0;
    sprHi    = '0;
    sprLo    = '0;
    sprAttr  = '0;
    fbCredit = 1'b0;
    tbEnable = 1'b0;
    expAddr  = '0;
    bgpVal   = '0;
    obp0Val  = '0;
    obp1Val  = '0;
    repeat (16) @(negedge iClock);
    rstN = 1'b1;
    testRegisters();
    testBackgroundOnly();
    testSpritePriority();
    testBackPressure();
    testCreditAccounting();
    testDisable();
    if (expQ.size() == 0 && rowsSent == TOTAL_ROWS)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      $display("rows sent %0d, words still owed %0d", rowsSent, expQ.size());
      $display("*** TEST FAILED ***");
      $fatal(1, "run ended with work left over");
    end
  end

endmodule
